/* build.f */
+incdir+design
design/fifo_pkg.sv
design/frame_pkg.sv
design/frame_if.sv
design/fifo_bank.sv
design/frame_decode.sv
design/frame_execute.sv
design/frame_result.sv
design/frame_fifo_top.sv
verification/frame_fifo_chk.sv
verification/frame_fifo_tb.sv

/* design/fifo_bank.sv */
`include "fifo_params.svh"

module fifo_bank (
	input  logic                       rd_clk,
	input  logic                       rst_read_n,
	input  logic                       wr_en,
	input  fifo_pkg::lane_array_t      wr_data,
	input  logic                       rd_en,
	output logic                       wr_full,
	output logic                       wr_overflow,
	output logic                       rd_empty,
	output logic                       rd_underflow,
	output logic                       rst_done,
	output logic                       out_valid,
	output wire fifo_pkg::lane_array_t out_word
);
	import fifo_pkg::*;

	localparam int SETTLE_W = $clog2(`FIFO_RST_CYCLES + 1);

	logic [SETTLE_W-1:0]       settle_cnt;   // Clocks since reset released.
	fifo_addr_t                wr_ptr;       // Shared by every lane.
	fifo_addr_t                rd_ptr;
	logic                      wr_accept;
	logic                      rd_accept;
	wire [`FIFO_NUM_LANES-1:0] lane_full;
	wire [`FIFO_NUM_LANES-1:0] lane_empty;

	////////////////////
	// Settle counter

	always_ff @(posedge rd_clk) begin
		if (rst_read_n) begin
			settle_cnt <= '0;
			rst_done   <= 1'b0;
		end else if (!rst_done) begin
			settle_cnt <= settle_cnt + 1'b1;
			if (settle_cnt == SETTLE_W'(`FIFO_RST_CYCLES - 1))
				rst_done <= 1'b1;          // Opens both ports next cycle.
		end
	end

	// Gang flags, any lane full or empty blocks the whole word.
	assign wr_full   = (|lane_full) || !rst_done;
	assign rd_empty  = (|lane_empty) || !rst_done;
	assign wr_accept = wr_en && !wr_full;
	assign rd_accept = rd_en && !rd_empty;

	////////////////////
	// Pointers and strobes

	always_ff @(posedge rd_clk) begin
		if (rst_read_n) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			wr_overflow  <= 1'b0;
			rd_underflow <= 1'b0;
			out_valid    <= 1'b0;
		end else begin
			if (wr_accept)
				wr_ptr <= wr_ptr + 1'b1;      // Wraps on power-of-two depth.
			if (rd_accept)
				rd_ptr <= rd_ptr + 1'b1;
			wr_overflow  <= wr_en && rst_done && wr_full;    // Word is dropped.
			rd_underflow <= rd_en && rst_done && rd_empty;
			out_valid    <= rd_accept;                       // Matches registered output.
		end
	end

	////////////////////
	// Lane memories

	for (genvar g = 0; g < `FIFO_NUM_LANES; g++) begin : g_lane
		lane_t       mem [`FIFO_DEPTH];   // Block storage for this lane.
		lane_t       lane_q;              // Registered read data.
		fifo_count_t count;               // Lane occupancy.
		fifo_count_t count_next;
		logic        full_q;
		logic        empty_q;

		always_comb begin
			count_next = count;
			if (wr_accept && !rd_accept)
				count_next = count + 1'b1;
			else if (rd_accept && !wr_accept)
				count_next = count - 1'b1;   // Write with read leaves it alone.
		end

		always_ff @(posedge rd_clk) begin
			if (rst_read_n) begin
				count   <= '0;
				full_q  <= 1'b0;
				empty_q <= 1'b1;
			end else begin
				count   <= count_next;
				full_q  <= (count_next == fifo_count_t'(`FIFO_DEPTH));
				empty_q <= (count_next == '0);
			end
		end

		always_ff @(posedge rd_clk) begin
			if (wr_accept)
				mem[wr_ptr] <= wr_data[g];
			if (rd_accept)
				lane_q <= mem[rd_ptr];      // Output register, no fall-through.
		end

		assign lane_full[g]  = full_q;
		assign lane_empty[g] = empty_q;
		assign out_word[g]   = lane_q;
	end

endmodule

/* design/fifo_params.svh */
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

////////////////////
// Lane geometry

`define FIFO_LANE_DATA   64                                      // Data bits per lane.
`define FIFO_LANE_PARITY 8                                       // One parity bit per data byte.
`define FIFO_LANE_WIDTH  (`FIFO_LANE_DATA + `FIFO_LANE_PARITY)   // Full lane word, 72 bits.

////////////////////
// Bank shape

`define FIFO_NUM_LANES   2    // Ganged lanes, 1 to 3 all work.
`define FIFO_DEPTH       16   // Words per lane, power of two up to 512.

// Clocks spent settling after reset before traffic is allowed.
`define FIFO_RST_CYCLES  12

`endif

/* design/fifo_pkg.sv */
`include "fifo_params.svh"

package fifo_pkg;

	////////////////////
	// Storage types

	// One lane word, parity sits above data as in the hard FIFO DIP/DI split.
	typedef struct packed {
		logic [`FIFO_LANE_PARITY-1:0] parity;   // Bit i covers data byte i.
		logic [`FIFO_LANE_DATA-1:0]   data;     // Raw lane payload.
	} lane_t;

	// Full ganged word, lane 0 in the low bits.
	typedef lane_t [`FIFO_NUM_LANES-1:0] lane_array_t;

	// Shared read and write address.
	typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_addr_t;

	// Occupancy, one extra bit so a full lane can be told from an empty one.
	typedef logic [$clog2(`FIFO_DEPTH):0] fifo_count_t;

endpackage

/* design/frame_decode.sv */
module frame_decode (
	input  logic                  rd_clk,
	input  logic                  rst_read_n,
	input  logic                  in_valid,
	input  fifo_pkg::lane_array_t in_word,
	decode_if.source              dec
);
	import frame_pkg::*;

	fifo_word_t in_view;      // Bank word seen through the union.
	frame_len_t words_left;   // Data words still owed by this frame.
	logic       at_header;    // Next word opens a frame.

	assign in_view   = fifo_word_t'(in_word);
	assign at_header = (words_left == '0);

	////////////////////
	// Frame tracking

	always_ff @(posedge rd_clk) begin
		if (rst_read_n) begin
			words_left    <= '0;
			dec.valid     <= 1'b0;
			dec.is_header <= 1'b0;
			dec.last      <= 1'b0;
		end else begin
			dec.valid <= in_valid;
			if (in_valid) begin
				dec.is_header <= at_header;
				if (at_header) begin
					// Length comes straight from the header view.
					words_left <= in_view.header.frame_len;
					dec.last   <= (in_view.header.frame_len == '0);   // Header-only frame.
				end else begin
					words_left <= words_left - 1'b1;
					dec.last   <= (words_left == frame_len_t'(1));    // Final data word.
				end
			end
		end
	end

	////////////////////
	// Word register

	always_ff @(posedge rd_clk) begin
		if (in_valid)
			dec.word <= in_view;   // Both views travel on.
	end

endmodule

/* design/frame_execute.sv */
`include "fifo_params.svh"

module frame_execute (
	input  logic      rd_clk,
	input  logic      rst_read_n,
	decode_if.sink    dec,
	execute_if.source exe
);
	import frame_pkg::*;

	localparam int BYTE_W = `FIFO_LANE_DATA / `FIFO_LANE_PARITY;

	logic [`FIFO_NUM_LANES-1:0][`FIFO_LANE_PARITY-1:0] byte_bad;   // Per byte parity miss.
	payload_t                                          data_bits;  // Lanes minus parity.

	////////////////////
	// Parity and payload

	always_comb begin
		for (int l = 0; l < `FIFO_NUM_LANES; l++) begin
			data_bits[l*`FIFO_LANE_DATA +: `FIFO_LANE_DATA] = dec.word.lanes[l].data;
			for (int b = 0; b < `FIFO_LANE_PARITY; b++) begin
				// Good byte when its parity bit equals the byte XOR.
				byte_bad[l][b] = (^dec.word.lanes[l].data[b*BYTE_W +: BYTE_W])
					!= dec.word.lanes[l].parity[b];
			end
		end
	end

	////////////////////
	// Stage register

	always_ff @(posedge rd_clk) begin
		if (rst_read_n) begin
			exe.valid     <= 1'b0;
			exe.is_header <= 1'b0;
			exe.last      <= 1'b0;
			exe.par_err   <= 1'b0;
		end else begin
			exe.valid <= dec.valid;
			if (dec.valid) begin
				exe.is_header <= dec.is_header;
				exe.last      <= dec.last;
				exe.par_err   <= !dec.is_header && (|byte_bad);   // Headers carry no parity.
			end
		end
	end

	always_ff @(posedge rd_clk) begin
		if (dec.valid && !dec.is_header)
			exe.payload <= data_bits;
		if (dec.valid && dec.is_header) begin
			exe.tag <= dec.word.header.frame_tag;   // Header view of the same word.
			exe.len <= dec.word.header.frame_len;
		end
	end

endmodule

/* design/frame_fifo_top.sv */
`include "fifo_params.svh"

module frame_fifo_top (
	input  logic                                         rd_clk,
	input  logic                                         rst_read_n,
	input  logic                                         wr_en,
	input  logic [`FIFO_NUM_LANES*`FIFO_LANE_WIDTH-1:0] wr_data,
	input  logic                                         rd_en,
	output logic                                         wr_full,
	output logic                                         wr_overflow,
	output logic                                         rd_empty,
	output logic                                         rd_underflow,
	output logic                                         rst_done,
	output logic                                         rd_valid,
	output logic [`FIFO_NUM_LANES*`FIFO_LANE_DATA-1:0]  rd_data,
	output logic                                         frame_done,
	output frame_pkg::frame_tag_t                        frame_tag,
	output frame_pkg::frame_len_t                        frame_words,
	output logic                                         frame_error
);
	import fifo_pkg::*;

	lane_array_t bank_word;    // Registered bank output.
	logic        bank_valid;

	decode_if  dec_if ();      // Decode to execute.
	execute_if exe_if ();      // Execute to result.

	////////////////////
	// Storage

	fifo_bank u_bank (
		.rd_clk       (rd_clk),
		.rst_read_n   (rst_read_n),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.rd_en        (rd_en),
		.wr_full      (wr_full),
		.wr_overflow  (wr_overflow),
		.rd_empty     (rd_empty),
		.rd_underflow (rd_underflow),
		.rst_done     (rst_done),
		.out_valid    (bank_valid),
		.out_word     (bank_word)
	);

	////////////////////
	// Read pipeline

	frame_decode u_decode (.rd_clk(rd_clk), .rst_read_n(rst_read_n),
		.in_valid(bank_valid), .in_word(bank_word), .dec(dec_if.source));

	frame_execute u_execute (.rd_clk(rd_clk), .rst_read_n(rst_read_n),
		.dec(dec_if.sink), .exe(exe_if.source));

	frame_result u_result (
		.rd_clk      (rd_clk),
		.rst_read_n  (rst_read_n),
		.exe         (exe_if.sink),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data),
		.frame_done  (frame_done),
		.frame_tag   (frame_tag),
		.frame_words (frame_words),
		.frame_error (frame_error)
	);

endmodule

/* design/frame_if.sv */
////////////////////
// Decode to execute

interface decode_if;
	import frame_pkg::*;

	logic       valid;       // One word this cycle.
	logic       is_header;   // Word is a frame header.
	logic       last;        // Final word of its frame.
	fifo_word_t word;        // Raw word, both views available.

	modport source (
		output valid,
		output is_header,
		output last,
		output word
	);

	modport sink (
		input valid,
		input is_header,
		input last,
		input word
	);
endinterface

////////////////////
// Execute to result

interface execute_if;
	import frame_pkg::*;

	logic       valid;       // One word this cycle.
	logic       is_header;   // Header, tag and len are good.
	logic       last;        // Closes the frame.
	payload_t   payload;     // Data bits of a data word.
	logic       par_err;     // Some byte failed its parity.
	frame_tag_t tag;         // Header tag.
	frame_len_t len;         // Header length.

	modport source (output valid, output is_header, output last, output payload,
		output par_err, output tag, output len);
	modport sink (input valid, input is_header, input last, input payload,
		input par_err, input tag, input len);
endinterface

/* design/frame_pkg.sv */
`include "fifo_params.svh"

package frame_pkg;

	////////////////////
	// Frame fields

	typedef logic [15:0] frame_tag_t;   // Frame identifier from the header.
	typedef logic [7:0]  frame_len_t;   // Data words after the header.

	// Payload of one data word, lanes stripped of parity.
	typedef logic [`FIFO_NUM_LANES*`FIFO_LANE_DATA-1:0] payload_t;

	localparam int FRAME_WORD_W = `FIFO_NUM_LANES * `FIFO_LANE_WIDTH;
	localparam int HDR_RSVD_W   = FRAME_WORD_W - $bits(frame_tag_t) - $bits(frame_len_t);

	////////////////////
	// Word views

	// Header layout, padded out to the full ganged width.
	typedef struct packed {
		logic [HDR_RSVD_W-1:0] reserved;     // Ignored by the read path.
		frame_tag_t            frame_tag;    // Carried to frame_tag on frame_done.
		frame_len_t            frame_len;    // Zero gives a header-only frame.
	} frame_header_t;

	// Same 144 bits read either as a header or as parity-protected lanes.
	typedef union packed {
		frame_header_t          header;   // First word of a frame.
		fifo_pkg::lane_array_t  lanes;    // Every following data word.
	} fifo_word_t;

endpackage

/* design/frame_result.sv */
module frame_result (
	input  logic                  rd_clk,
	input  logic                  rst_read_n,
	execute_if.sink               exe,
	output logic                  rd_valid,
	output frame_pkg::payload_t   rd_data,
	output logic                  frame_done,
	output frame_pkg::frame_tag_t frame_tag,
	output frame_pkg::frame_len_t frame_words,
	output logic                  frame_error
);
	import frame_pkg::*;

	frame_tag_t cur_tag;      // Tag of the open frame.
	frame_len_t word_cnt;     // Data words seen so far.
	logic       err_sticky;   // Any parity miss in this frame.
	logic       data_beat;

	assign data_beat = exe.valid && !exe.is_header;

	////////////////////
	// Frame state

	always_ff @(posedge rd_clk) begin
		if (rst_read_n) begin
			rd_valid   <= 1'b0;
			frame_done <= 1'b0;
			word_cnt   <= '0;
			err_sticky <= 1'b0;
		end else begin
			rd_valid   <= data_beat;
			frame_done <= exe.valid && exe.last;   // One pulse per frame.
			if (exe.valid) begin
				if (exe.is_header) begin
					word_cnt   <= '0;                  // New frame starts clean.
					err_sticky <= 1'b0;
				end else begin
					word_cnt   <= word_cnt + 1'b1;
					err_sticky <= err_sticky || exe.par_err;
				end
			end
		end
	end

	////////////////////
	// Output registers

	always_ff @(posedge rd_clk) begin
		if (data_beat)
			rd_data <= exe.payload;
		if (exe.valid && exe.is_header)
			cur_tag <= exe.tag;
		if (exe.valid && exe.last) begin
			if (exe.is_header) begin
				frame_tag   <= exe.tag;       // Header-only frame.
				frame_words <= exe.len;
				frame_error <= 1'b0;
			end else begin
				frame_tag   <= cur_tag;
				frame_words <= word_cnt + 1'b1;   // Counts this last beat.
				frame_error <= err_sticky || exe.par_err;
			end
		end
	end

endmodule

/* verification/frame_fifo_chk.sv */
module frame_fifo_chk (
	input logic rd_clk,
	input logic rst_read_n,
	input logic rd_en,
	input logic rd_empty,
	input logic rd_underflow,
	input logic rd_valid,
	input logic frame_done,
	input logic dec_last
);
	int assert_errs = 0;   // Failed assertion count.

	// Outputs are quiet on the cycle after any reset edge.
	reset_quiet: assert property (@(posedge rd_clk) rst_read_n |=> !rd_valid && !frame_done)
		else begin
			$error("rd_valid or frame_done high after a reset edge");
			assert_errs++;
		end

	underflow_cause: assert property (@(posedge rd_clk) disable iff (rst_read_n)
		rd_underflow |-> $past(rd_en && rd_empty))
		else begin
			$error("rd_underflow without an empty read before it");
			assert_errs++;
		end

	// A data beat closes its frame only when decode marked that word last.
	done_on_last: assert property (@(posedge rd_clk) disable iff (rst_read_n)
		rd_valid |-> frame_done == $past(dec_last, 2))
		else begin
			$error("frame_done out of step with the last data word");
			assert_errs++;
		end

endmodule

bind frame_fifo_top frame_fifo_chk chk (
	.rd_clk       (rd_clk),
	.rst_read_n   (rst_read_n),
	.rd_en        (rd_en),
	.rd_empty     (rd_empty),
	.rd_underflow (rd_underflow),
	.rd_valid     (rd_valid),
	.frame_done   (frame_done),
	.dec_last     (dec_if.last)      // Decode stage last flag.
);

/* verification/frame_fifo_tb.sv */
`include "fifo_params.svh"

module frame_fifo_tb;
	localparam int LD = `FIFO_LANE_DATA;
	localparam int LW = `FIFO_LANE_WIDTH;
	localparam int WW = `FIFO_NUM_LANES * LW;   // Ganged word.
	localparam int PW = `FIFO_NUM_LANES * LD;   // Payload only.

	logic          rd_clk;
	logic          rst_read_n;
	logic          wr_en;
	logic          rd_en;
	logic [WW-1:0] wr_data;
	logic          wr_full, wr_overflow, rd_empty, rd_underflow, rst_done;
	logic          rd_valid, frame_done, frame_error;
	logic [PW-1:0] rd_data;
	logic [15:0]   frame_tag;
	logic [7:0]    frame_words;

	logic [31:0]   lfsr = 32'h3c62_bf78;
	logic [WW-1:0] wq[$];           // Words waiting to be written.
	logic [PW-1:0] exp_beats[$];    // Expected payloads in order.
	logic [24:0]   exp_frames[$];   // Expected {error, words, tag}.
	int            errors = 0;
	int            timeouts = 0;
	int            ovf_cnt = 0;     // wr_overflow cycles seen.
	int            udf_cnt = 0;
	int            occ = 0;         // Bank occupancy model.

	frame_fifo_top dut (.*);

	initial begin
		rd_clk = 1'b0;
		forever #2 rd_clk = ~rd_clk;
	end

	////////////////////
	// Helpers

	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] v = '0;
		logic        fb;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // Taps 32, 22, 2, 1.
			lfsr = {lfsr[30:0], fb};
			v    = {v[62:0], fb};
		end
		return v;
	endfunction

	function automatic logic [WW-1:0] data_word(logic [PW-1:0] p, logic flip);
		logic [WW-1:0] w;
		for (int l = 0; l < `FIFO_NUM_LANES; l++) begin
			w[l*LW +: LD] = p[l*LD +: LD];
			for (int b = 0; b < `FIFO_LANE_PARITY; b++)
				w[l*LW + LD + b] = ^p[l*LD + b*8 +: 8];   // Good byte parity.
		end
		w[LD + 3] = w[LD + 3] ^ flip;   // Lane 0, byte 3 parity.
		return w;
	endfunction

	task automatic check_val(string name, logic [PW-1:0] got, logic [PW-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic add_frame(logic [15:0] tag, int len, int bad);
		logic [PW-1:0] p;
		wq.push_back(WW'({tag, 8'(len)}));   // Header, reserved bits zero.
		for (int i = 0; i < len; i++) begin
			for (int l = 0; l < `FIFO_NUM_LANES; l++)
				p[l*LD +: LD] = rand_bits(LD);
			wq.push_back(data_word(p, i == bad));
			exp_beats.push_back(p);
		end
		exp_frames.push_back({bad >= 0 && bad < len, 8'(len), tag});
	endtask

	task automatic write_words();
		foreach (wq[i]) begin
			@(posedge rd_clk);
			wr_en   <= 1'b1;
			wr_data <= wq[i];
			@(negedge rd_clk);
			check_val("wr_full", wr_full, occ == `FIFO_DEPTH);   // State before this word.
			if (occ < `FIFO_DEPTH)
				occ++;
		end
		@(posedge rd_clk);
		wr_en <= 1'b0;
		@(negedge rd_clk);
		check_val("wr_full", wr_full, occ == `FIFO_DEPTH);
		wq.delete();
	endtask

	task automatic read_words(int n);
		for (int i = 0; i < n; i++) begin
			@(posedge rd_clk);
			rd_en <= 1'b1;
			@(negedge rd_clk);
			check_val("rd_empty", rd_empty, occ == 0);
			if (occ > 0)
				occ--;
		end
		@(posedge rd_clk);
		rd_en <= 1'b0;
		@(negedge rd_clk);
		check_val("rd_empty", rd_empty, occ == 0);
	endtask

	// Write one word per cycle, reads trail by two cycles.
	task automatic stream_words();
		int n = wq.size();
		for (int i = 0; i < n + 2; i++) begin
			@(posedge rd_clk);
			wr_en <= (i < n);
			if (i < n)
				wr_data <= wq[i];
			rd_en <= (i >= 2);
		end
		@(posedge rd_clk);
		rd_en <= 1'b0;
		wq.delete();
	endtask

	task automatic wait_drained(string what);
		int n = 0;
		while (exp_beats.size() + exp_frames.size() != 0 && n < 64) begin
			@(negedge rd_clk);
			n++;
		end
		if (exp_beats.size() + exp_frames.size() != 0) begin
			timeouts++;
			$display("timeout at %0t: %s left %0d beats and %0d frames unseen",
				$time, what, exp_beats.size(), exp_frames.size());
		end
	endtask

	task automatic reset_levels();
		check_val("wr_overflow", wr_overflow, 1'b0);
		check_val("rd_underflow", rd_underflow, 1'b0);
		check_val("rd_valid", rd_valid, 1'b0);
		check_val("frame_done", frame_done, 1'b0);
		check_val("rst_done", rst_done, 1'b0);
		check_val("wr_full", wr_full, 1'b1);
		check_val("rd_empty", rd_empty, 1'b1);
	endtask

	////////////////////
	// Output monitor

	always @(negedge rd_clk) begin
		logic [24:0] s;
		if (wr_overflow)
			ovf_cnt++;
		if (rd_underflow)
			udf_cnt++;
		if (rd_valid && exp_beats.size() == 0) begin
			errors++;
			$display("unexpected rd_valid beat at %0t", $time);
		end else if (rd_valid)
			check_val("rd_data", rd_data, exp_beats.pop_front());
		if (frame_done && exp_frames.size() == 0) begin
			errors++;
			$display("unexpected frame_done at %0t", $time);
		end else if (frame_done) begin
			s = exp_frames.pop_front();
			check_val("frame_tag", frame_tag, s[15:0]);
			check_val("frame_words", frame_words, s[23:16]);
			check_val("frame_error", frame_error, s[24]);
		end
	end

	////////////////////
	// Tests

	task automatic reset_state();
		int n = 0;
		repeat (15) begin
			@(negedge rd_clk);
			reset_levels();
		end
		@(posedge rd_clk);
		rst_read_n <= 1'b0;   // Sixteenth edge still sees reset.
		@(negedge rd_clk);
		reset_levels();
		while (!rst_done && n < 4 * `FIFO_RST_CYCLES) begin
			@(negedge rd_clk);
			n++;
			if (!rst_done)
				reset_levels();
		end
		if (!rst_done) begin
			timeouts++;
			$display("timeout at %0t: rst_done never rose after reset", $time);
		end else
			check_val("rst_done edge", n, `FIFO_RST_CYCLES);
	endtask

	task automatic single_frame();
		add_frame(16'ha51c, 3, -1);
		write_words();
		read_words(4);
		wait_drained("single frame");
	endtask

	task automatic parity_error();
		add_frame(16'hc3a0, 4, 1);    // Second data word corrupted.
		add_frame(16'hc3a1, 0, -1);   // Header only, clean.
		write_words();
		read_words(6);
		wait_drained("parity error");
	endtask

	task automatic full_overflow();
		int ovf0 = ovf_cnt;
		add_frame(16'h7e01, `FIFO_DEPTH - 2, -1);
		add_frame(16'h7e02, 0, -1);
		wq.push_back(WW'({16'hdead, 8'd5}));   // Dropped by the full bank.
		write_words();
		read_words(`FIFO_DEPTH);
		wait_drained("full bank");
		check_val("wr_overflow pulses", ovf_cnt - ovf0, 1);
	endtask

	task automatic underflow();
		int udf0 = udf_cnt;
		int n = 0;
		read_words(1);
		while (udf_cnt == udf0 && n < 8) begin
			@(negedge rd_clk);
			n++;
		end
		if (udf_cnt == udf0) begin
			timeouts++;
			$display("timeout at %0t: no rd_underflow after an empty read", $time);
		end
		repeat (4) @(negedge rd_clk);   // Window for a stray beat or second pulse.
		check_val("rd_underflow pulses", udf_cnt - udf0, 1);
	endtask

	task automatic streaming();
		int len;
		int bad;
		for (int f = 0; f < 6; f++) begin
			len = 1 + int'(rand_bits(3));
			bad = (rand_bits(2) == 0) ? int'(rand_bits(3)) % len : -1;   // About one in four.
			add_frame(16'(rand_bits(16)), len, bad);
		end
		stream_words();
		wait_drained("streaming");
	endtask

	initial begin
		rst_read_n = 1'b1;
		wr_en      = 1'b0;
		rd_en      = 1'b0;
		wr_data    = '0;
		reset_state();
		single_frame();
		parity_error();
		full_overflow();
		underflow();
		streaming();
		$display("errors %0d, timeouts %0d, assertion failures %0d",
			errors, timeouts, dut.chk.assert_errs);
		if (errors + timeouts + dut.chk.assert_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
